//--- Bender.yml
package:
  name: exec_unit

sources:
  - design/core_cfg_pkg.sv
  - design/alu_op_pkg.sv
  - design/div_unit.sv
  - design/alu_core.sv
  - design/exec_unit.sv
  - target: test
    files:
      - dv/tb_exec_unit.sv

//--- design/alu_core.sv
/*
 * Integer ALU datapath. Simple ops are combinational; SRA and multiplies
 * take one registered cycle, divides are handed to the iterative divider.
 * busy_o tells the surrounding stage to hold op and operands.
 */

`timescale 1ns/10ps

module alu_core
    import core_cfg_pkg::*, alu_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flow_wait_i,
    input  alu_op_e    op_i,
    input  word_t      src1_i,
    input  word_t      src2_i,
    input  div_rsp_t   div_rsp_i,
    output div_req_t   div_req_o,
    output word_t      res_o,
    output alu_flags_t flags_o,
    output logic       busy_o
);

    word_t     src1_abs;
    word_t     src2_abs;
    logic      src1_neg;
    logic      src2_neg;
    logic      slt_s;
    logic      slt_u;
    dword_t    sra_ext;
    dword_t    ext_nxt;
    dword_t    ext_q;
    logic      ext_flag_q;
    logic      is_ext_op;
    logic      is_div_op;
    logic      ext_capture;
    dword_t    prod;
    dword_t    prod_neg;
    logic      div_start;
    logic      div_run_q;
    div_kind_e div_kind;

    // --------------------
    // Operand preparation

    assign src1_neg = src1_i[XLEN-1];
    assign src2_neg = src2_i[XLEN-1];
    assign src1_abs = src1_neg ? (~src1_i + 1'b1) : src1_i;
    assign src2_abs = src2_neg ? (~src2_i + 1'b1) : src2_i;

    assign slt_s = $signed(src1_i) < $signed(src2_i);
    assign slt_u = src1_i < src2_i;

    // Arithmetic shift done on the sign-extended double word
    assign sra_ext = {{XLEN{src1_neg}}, src1_i} >> src2_i[SHAMT_W-1:0];

    assign is_ext_op = op_i inside {ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHU, ALU_MULHSU};
    assign is_div_op = op_i inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

    // First unstalled cycle of a two-cycle op
    assign ext_capture = is_ext_op && !ext_flag_q && !flow_wait_i;

    // Unsigned product of the captured pair
    assign prod     = ext_q[2*XLEN-1:XLEN] * ext_q[XLEN-1:0];
    assign prod_neg = ~prod + 1'b1;

    // --------------------
    // Extension register

    always_comb begin
        case (op_i)
            ALU_SRA:    ext_nxt = sra_ext;
            ALU_MULH:   ext_nxt = {src1_abs, src2_abs};
            ALU_MULHSU: ext_nxt = {src1_abs, src2_i};
            default:    ext_nxt = {src1_i, src2_i};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_flag_q <= 1'b0;
        end else begin
            ext_flag_q <= ext_capture;
        end
    end

    always_ff @(posedge clk) begin
        if (ext_capture) begin
            ext_q <= ext_nxt;
        end
    end

    // --------------------
    // Divider request

    // A running divide keeps start up even if the stage stalls
    assign div_start = is_div_op && !div_rsp_i.done && (div_run_q || !flow_wait_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_run_q <= 1'b0;
        end else begin
            div_run_q <= div_start;
        end
    end

    always_comb begin
        case (op_i)
            ALU_DIVU: div_kind = DK_DIVU;
            ALU_REM:  div_kind = DK_REM;
            ALU_REMU: div_kind = DK_REMU;
            default:  div_kind = DK_DIV;
        endcase
    end

    assign div_req_o.start    = div_start;
    assign div_req_o.kind     = div_kind;
    assign div_req_o.dividend = src1_i;
    assign div_req_o.divisor  = src2_i;

    // --------------------
    // Result and flags

    always_comb begin
        res_o   = '0;
        flags_o = '0;
        busy_o  = ext_capture || div_start;
        case (op_i)
            ALU_ADD: res_o = src1_i + src2_i;
            ALU_SUB: begin
                res_o        = src1_i - src2_i;
                flags_o.zero = (src1_i == src2_i);
            end
            ALU_XOR: res_o = src1_i ^ src2_i;
            ALU_OR:  res_o = src1_i | src2_i;
            ALU_AND: res_o = src1_i & src2_i;
            ALU_SLL: res_o = src1_i << src2_i[SHAMT_W-1:0];
            ALU_SRL: res_o = src1_i >> src2_i[SHAMT_W-1:0];
            ALU_SLT: begin
                res_o           = {{(XLEN-1){1'b0}}, slt_s};
                flags_o.less    = slt_s;
                flags_o.ge_zero = !slt_s;
            end
            ALU_SLTU: begin
                res_o           = {{(XLEN-1){1'b0}}, slt_u};
                flags_o.less    = slt_u;
                flags_o.ge_zero = !slt_u;
            end
            ALU_SRA: res_o = ext_q[XLEN-1:0];
            ALU_MUL: res_o = prod[XLEN-1:0];
            // Sign fix-up on the magnitude product
            ALU_MULH:   res_o = (src1_neg ^ src2_neg) ? prod_neg[2*XLEN-1:XLEN]
                                                      : prod[2*XLEN-1:XLEN];
            ALU_MULHU:  res_o = prod[2*XLEN-1:XLEN];
            ALU_MULHSU: res_o = src1_neg ? prod_neg[2*XLEN-1:XLEN]
                                         : prod[2*XLEN-1:XLEN];
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: begin
                if (div_rsp_i.done) begin
                    res_o = div_rsp_i.result;
                end
            end
            default: res_o = '0;
        endcase
    end

    // --------------------
    // Checks

    // Request stays up and unchanged until the divider answers
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        div_req_o.start && !div_rsp_i.done |=> div_rsp_i.done || $stable(div_req_o));

    a_idle_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        div_rsp_i.done |-> !busy_o);

endmodule : alu_core

//--- design/alu_op_pkg.sv
/*
 * ALU operation codes, compare flags and the request/response words
 * exchanged between the ALU core and the iterative divider.
 */

package alu_op_pkg;

    import core_cfg_pkg::*;

    // --------------------
    // Operation codes

    typedef enum logic [4:0] {
        ALU_ADD    = 5'h00,
        ALU_SUB    = 5'h01,
        ALU_XOR    = 5'h02,
        ALU_OR     = 5'h03,
        ALU_AND    = 5'h04,
        ALU_SLL    = 5'h05,
        ALU_SRL    = 5'h06,
        ALU_SRA    = 5'h07,
        ALU_SLT    = 5'h08,
        ALU_SLTU   = 5'h09,
        ALU_MUL    = 5'h0A,
        ALU_MULH   = 5'h0B,
        ALU_MULHU  = 5'h0C,
        ALU_MULHSU = 5'h0D,
        ALU_DIV    = 5'h0E,
        ALU_DIVU   = 5'h0F,
        ALU_REM    = 5'h10,
        ALU_REMU   = 5'h11,
        ALU_NOP    = 5'h1F
    } alu_op_e;

    // Divider operation, signed kinds are DIV and REM
    typedef enum logic [1:0] {
        DK_DIV  = 2'd0,
        DK_DIVU = 2'd1,
        DK_REM  = 2'd2,
        DK_REMU = 2'd3
    } div_kind_e;

    // --------------------
    // Flags and divider words

    // zero from SUB, less and ge_zero from SLT/SLTU
    typedef struct packed {
        logic zero;
        logic less;
        logic ge_zero;
    } alu_flags_t;

    typedef struct packed {
        logic      start;
        div_kind_e kind;
        word_t     dividend;
        word_t     divisor;
    } div_req_t;

    typedef struct packed {
        logic  done;
        word_t result;
    } div_rsp_t;

endpackage : alu_op_pkg

//--- design/core_cfg_pkg.sv
/*
 * Core-wide data width and word types.
 * Import into any block that carries operands or results of the integer core.
 */

package core_cfg_pkg;

    // --------------------
    // Data width

    // Register and operand width
    parameter int XLEN = 32;

    // Shift amount field, taken from the low bits of source 2
    parameter int SHAMT_W = 5;

    // --------------------
    // Word types

    // One operand or result word
    typedef logic [XLEN-1:0] word_t;

    // Full product or sign-extended shift value
    typedef logic [2*XLEN-1:0] dword_t;

endpackage : core_cfg_pkg

//--- design/div_unit.sv
/*
 * Iterative restoring divider, BITS_PER_CYCLE quotient bits per clock.
 * Latches a request on start while idle and answers with a one-cycle done.
 */

`timescale 1ns/10ps

module div_unit
    import core_cfg_pkg::*, alu_op_pkg::*;
#(
    parameter int BITS_PER_CYCLE = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  div_req_t div_req_i,
    output div_rsp_t div_rsp_o
);

    localparam int STEPS = XLEN / BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             start_ok;
    logic             signed_op;
    div_kind_e        kind_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             zero_div_q;
    word_t            dividend_abs;
    word_t            divisor_abs;
    word_t            rem_q;
    word_t            quo_q;
    word_t            divisor_q;
    word_t            rem_nxt;
    word_t            quo_nxt;
    word_t            quo_fix;
    word_t            rem_fix;

    // --------------------
    // Request latch

    assign start_ok  = (state_q == S_IDLE) && div_req_i.start;
    assign signed_op = (div_req_i.kind == DK_DIV) || (div_req_i.kind == DK_REM);

    assign dividend_abs = (signed_op && div_req_i.dividend[XLEN-1])
                        ? (~div_req_i.dividend + 1'b1) : div_req_i.dividend;
    assign divisor_abs  = (signed_op && div_req_i.divisor[XLEN-1])
                        ? (~div_req_i.divisor + 1'b1) : div_req_i.divisor;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (div_req_i.start) begin
                        state_q <= S_RUN;
                        cnt_q   <= '0;
                    end
                end
                S_RUN: begin
                    if (cnt_q == CNT_W'(STEPS - 1)) begin
                        state_q <= S_DONE;
                    end
                    cnt_q <= cnt_q + 1'b1;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            kind_q     <= div_req_i.kind;
            neg_quo_q  <= signed_op && (div_req_i.dividend[XLEN-1] ^ div_req_i.divisor[XLEN-1]);
            neg_rem_q  <= signed_op && div_req_i.dividend[XLEN-1];
            zero_div_q <= (div_req_i.divisor == '0);
            rem_q      <= '0;
            quo_q      <= dividend_abs;
            divisor_q  <= divisor_abs;
        end else if (state_q == S_RUN) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

    // --------------------
    // Restoring steps

    always_comb begin : restore_steps
        logic [XLEN:0] part;
        word_t         rem_v;
        word_t         quo_v;
        rem_v = rem_q;
        quo_v = quo_q;
        part  = '0;
        for (int i = 0; i < BITS_PER_CYCLE; i++) begin
            // Dividend bits shift out of the quotient into the remainder
            part  = {rem_v, quo_v[XLEN-1]};
            quo_v = {quo_v[XLEN-2:0], 1'b0};
            if (part >= {1'b0, divisor_q}) begin
                part     = part - {1'b0, divisor_q};
                quo_v[0] = 1'b1;
            end
            rem_v = part[XLEN-1:0];
        end
        rem_nxt = rem_v;
        quo_nxt = quo_v;
    end

    // --------------------
    // Sign fix-up and response

    // Overflow case already yields the most negative quotient and zero remainder
    assign quo_fix = zero_div_q ? '1 : (neg_quo_q ? (~quo_q + 1'b1) : quo_q);
    assign rem_fix = neg_rem_q ? (~rem_q + 1'b1) : rem_q;

    assign div_rsp_o.done   = (state_q == S_DONE);
    assign div_rsp_o.result = (kind_q == DK_REM || kind_q == DK_REMU) ? rem_fix : quo_fix;

    // --------------------
    // Checks

    // One done cycle, STEPS + 1 cycles after the request is latched
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        start_ok |-> ##(STEPS+1) div_rsp_o.done ##1 !div_rsp_o.done);

    a_step_fit: assert property (@(posedge clk) disable iff (!rst_n)
        (XLEN % BITS_PER_CYCLE) == 0);

endmodule : div_unit

//--- design/exec_unit.sv
/*
 * Execute block top. Joins the ALU core with the iterative divider;
 * BITS_PER_CYCLE sets the divider speed (1, 2 or 4).
 */

`timescale 1ns/10ps

module exec_unit
    import core_cfg_pkg::*, alu_op_pkg::*;
#(
    parameter int BITS_PER_CYCLE = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flow_wait_i,
    input  alu_op_e    op_i,
    input  word_t      src1_i,
    input  word_t      src2_i,
    output word_t      res_o,
    output alu_flags_t flags_o,
    output logic       busy_o
);

    div_req_t div_req;
    div_rsp_t div_rsp;

    // --------------------
    // Datapath and op decode

    alu_core i_alu_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .flow_wait_i (flow_wait_i),
        .op_i        (op_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .div_rsp_i   (div_rsp),
        .div_req_o   (div_req),
        .res_o       (res_o),
        .flags_o     (flags_o),
        .busy_o      (busy_o)
    );

    // --------------------
    // Divider

    div_unit #(
        .BITS_PER_CYCLE (BITS_PER_CYCLE)
    ) i_div_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_req_i (div_req),
        .div_rsp_o (div_rsp)
    );

endmodule : exec_unit

//--- dv/alu_stimulus.txt
// All fields hex: op src1 src2 expected_result expected_flags
// Flags are {zero, less, ge_zero}
00 7FFFFFFF 00000001 80000000 0
01 12345678 12345678 00000000 4
01 00000005 00000007 FFFFFFFE 0
02 F0F0F0F0 0FF00FF0 FF00FF00 0
03 A5A50000 00005A5A A5A55A5A 0
04 DEADBEEF 0000FFFF 0000BEEF 0
05 00000003 00000024 00000030 0
06 80000000 00000004 08000000 0
08 FFFFFFFF 00000001 00000001 2
09 FFFFFFFF 00000001 00000000 1
07 80000000 00000004 F8000000 0
07 7FFFFFFF 00000001 3FFFFFFF 0
0A 00012345 00006789 75CCA2ED 0
0B 80000000 7FFFFFFF C0000000 0
0C FFFFFFFF FFFFFFFF FFFFFFFE 0
0D FFFFFFFF FFFFFFFF FFFFFFFF 0
0E FFFFFFF9 00000002 FFFFFFFD 0
10 FFFFFFF9 00000002 FFFFFFFF 0
0F FFFFFFF9 00000002 7FFFFFFC 0
11 FFFFFFF9 00000002 00000001 0
0E 12345678 00000000 FFFFFFFF 0
10 12345678 00000000 12345678 0
0E 80000000 FFFFFFFF 80000000 0
10 80000000 FFFFFFFF 00000000 0
1F 00000000 00000000 00000000 0

//--- dv/tb_exec_unit.sv
/*
 * Testbench for the execute block. Vectors from the stimulus file are applied
 * one at a time, sometimes behind a one-cycle stall. Result, flags and latency
 * are checked against the file and the timing rules of each op class.
 */

`timescale 1ns/10ps

module tb_exec_unit
    import core_cfg_pkg::*, alu_op_pkg::*;
();

    localparam int    BITS_PER_CYCLE = 1;
    localparam int    RESET_CYCLES   = 16;
    localparam string STIM_FILE      = "dv/alu_stimulus.txt";

    // One line of the stimulus file
    typedef struct packed {
        alu_op_e    op;
        word_t      src1;
        word_t      src2;
        word_t      res;
        alu_flags_t flags;
    } vector_t;

    logic        clk;
    logic        rst_n;
    logic        flow_wait;
    alu_op_e     op;
    word_t       src1;
    word_t       src2;
    word_t       res;
    alu_flags_t  flags;
    logic        busy;
    vector_t     vectors[$];
    logic [15:0] lfsr_q;
    int          cycle_cnt;
    int          cycle_limit;
    int          word_errs;
    int          flag_errs;
    int          timing_errs;

    // --------------------
    // Clock and DUT

    initial clk = 1'b0;
    always #5 clk = ~clk;

    exec_unit #(
        .BITS_PER_CYCLE (BITS_PER_CYCLE)
    ) i_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .flow_wait_i (flow_wait),
        .op_i        (op),
        .src1_i      (src1),
        .src2_i      (src2),
        .res_o       (res),
        .flags_o     (flags),
        .busy_o      (busy)
    );

    // --------------------
    // Helpers

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    // Cycles from first unstalled cycle up to and including the result cycle
    function automatic int expected_latency(input alu_op_e op_v);
        case (op_v)
            ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHU, ALU_MULHSU: return 2;
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: return XLEN / BITS_PER_CYCLE + 2;
            default: return 1;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_flags(input string name, input alu_flags_t got,
                               input alu_flags_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s: got %h cycles, expected %h", name, got, exp);
            timing_errs++;
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            timing_errs++;
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d result errors, %0d flag errors, %0d timing errors",
                 word_errs, flag_errs, timing_errs);
    endtask

    // Comment and blank lines fail the scan and are skipped
    task automatic load_vectors(output int count);
        int         fd;
        int         n;
        string      line;
        logic [4:0] op_raw;
        word_t      s1;
        word_t      s2;
        word_t      r;
        logic [2:0] f_raw;
        vector_t    v;
        count = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%h %h %h %h %h",
                                     op_raw, s1, s2, r, f_raw) == 5) begin
                    v.op    = alu_op_e'(op_raw);
                    v.src1  = s1;
                    v.src2  = s2;
                    v.res   = r;
                    v.flags = alu_flags_t'(f_raw);
                    vectors.push_back(v);
                end
            end
            $fclose(fd);
            count = vectors.size();
        end
    endtask

    task automatic run_vector(input vector_t v);
        int    cycles;
        logic  stall;
        string tag;
        stall  = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
        tag    = v.op.name();
        @(negedge clk);
        op        = v.op;
        src1      = v.src1;
        src2      = v.src2;
        flow_wait = stall;
        // Back-pressure holds off the op entirely
        if (stall) begin
            @(posedge clk);
            check_busy({"busy_o stalled ", tag}, busy, 1'b0);
            @(negedge clk);
            flow_wait = 1'b0;
        end
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (busy);
        check_word({"res_o ", tag}, res, v.res);
        check_flags({"flags_o ", tag}, flags, v.flags);
        check_latency({"busy_o ", tag}, cycles, expected_latency(v.op));
    endtask

    // --------------------
    // Timeout

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            print_summary();
            $display("Test failures found");
            $finish;
        end
    end

    // --------------------
    // Main sequence

    initial begin
        int n_vec;
        rst_n       = 1'b0;
        flow_wait   = 1'b0;
        op          = ALU_NOP;
        src1        = '0;
        src2        = '0;
        lfsr_q      = 16'd36;
        cycle_cnt   = 0;
        cycle_limit = 0;
        word_errs   = 0;
        flag_errs   = 0;
        timing_errs = 0;
        load_vectors(n_vec);
        if (n_vec == 0) begin
            $display("No vectors could be read from %s", STIM_FILE);
            $display("Test failures found");
            $finish;
        end else begin
            cycle_limit = n_vec * (XLEN + 8) + 100;
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            @(posedge clk);
            check_busy("busy_o after reset", busy, 1'b0);
            foreach (vectors[i]) begin
                run_vector(vectors[i]);
            end
            print_summary();
            if (word_errs + flag_errs + timing_errs == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule : tb_exec_unit

//--- filelist.f
design/core_cfg_pkg.sv
design/alu_op_pkg.sv
design/div_unit.sv
design/alu_core.sv
design/exec_unit.sv
dv/tb_exec_unit.sv
